//--- compile.f
design/cpu_pkg.sv
design/reg_file.sv
design/inst_fetch.sv
design/decode_stage.sv
design/hazard_unit.sv
design/execute_stage.sv
design/mycpu_top.sv
testbench/mycpu_checker.sv
testbench/tb_mycpu_top.sv

//--- design/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam word_t inst_bytes = 32'd4;   // pc step

    // major opcodes
    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_beq     = 6'h04;
    localparam opcode_t op_bne     = 6'h05;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_lui     = 6'h0f;

    // funct field under op_special
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui,    // operand b moved to the upper half
        alu_nop
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_rf,
        fwd_ex,
        fwd_wb
    } fwd_sel_t;

endpackage

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               id_valid,
    input  cpu_pkg::word_t     id_pc,
    input  cpu_pkg::word_t     id_instr,
    input  logic               id_stall,
    input  cpu_pkg::fwd_sel_t  fwd_a,
    input  cpu_pkg::fwd_sel_t  fwd_b,
    input  cpu_pkg::word_t     ex_result,
    input  cpu_pkg::word_t     wb_result,
    input  cpu_pkg::word_t     rdata_a,
    input  cpu_pkg::word_t     rdata_b,
    output logic               id_advance,
    output logic               branch_taken,
    output cpu_pkg::word_t     branch_target,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rt,
    output logic               rs_used,
    output logic               rt_used,
    output logic               branch_uses,
    output cpu_pkg::reg_addr_t raddr_a,
    output cpu_pkg::reg_addr_t raddr_b,
    output logic               ex_valid,
    output cpu_pkg::word_t     ex_pc,
    output cpu_pkg::alu_op_t   ex_alu_op,
    output cpu_pkg::word_t     ex_op_a,
    output cpu_pkg::word_t     ex_op_b,
    output cpu_pkg::reg_addr_t ex_dst,
    output logic               ex_wr
);

    cpu_pkg::opcode_t   opcode;
    cpu_pkg::funct_t    funct;
    cpu_pkg::reg_addr_t rd;
    logic [15:0]        imm;
    cpu_pkg::alu_op_t   alu_op;
    logic               wr;
    cpu_pkg::reg_addr_t dst;
    logic               use_imm;
    logic               imm_zero;   // zero extension for ori and lui
    logic               is_beq;
    logic               is_bne;
    cpu_pkg::word_t     val_a;
    cpu_pkg::word_t     val_b;
    cpu_pkg::word_t     imm_ext;

    function automatic cpu_pkg::word_t pick(cpu_pkg::fwd_sel_t sel, cpu_pkg::word_t rf_val);
        case (sel)
            cpu_pkg::fwd_ex: return ex_result;
            cpu_pkg::fwd_wb: return wb_result;
            default:         return rf_val;
        endcase
    endfunction

    assign opcode  = id_instr[31:26];
    assign rs      = id_instr[25:21];
    assign rt      = id_instr[20:16];
    assign rd      = id_instr[15:11];
    assign imm     = id_instr[15:0];
    assign funct   = id_instr[5:0];
    assign raddr_a = rs;
    assign raddr_b = rt;

    always_comb begin
        alu_op   = cpu_pkg::alu_nop;
        wr       = 1'b0;
        dst      = rd;
        rs_used  = 1'b0;
        rt_used  = 1'b0;
        use_imm  = 1'b0;
        imm_zero = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        if (id_valid) begin
            case (opcode)
                cpu_pkg::op_special: begin
                    case (funct)
                        cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                        cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                        cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                        cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                        cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
                        cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                        default:          alu_op = cpu_pkg::alu_nop;
                    endcase
                    wr      = (alu_op != cpu_pkg::alu_nop);   // unknown funct is a no-op
                    rs_used = wr;
                    rt_used = wr;
                end
                cpu_pkg::op_addiu: begin
                    alu_op  = cpu_pkg::alu_add;
                    wr      = 1'b1;
                    dst     = rt;
                    rs_used = 1'b1;
                    use_imm = 1'b1;
                end
                cpu_pkg::op_ori: begin
                    alu_op   = cpu_pkg::alu_or;
                    wr       = 1'b1;
                    dst      = rt;
                    rs_used  = 1'b1;
                    use_imm  = 1'b1;
                    imm_zero = 1'b1;
                end
                cpu_pkg::op_lui: begin
                    alu_op   = cpu_pkg::alu_lui;
                    wr       = 1'b1;
                    dst      = rt;
                    use_imm  = 1'b1;
                    imm_zero = 1'b1;
                end
                cpu_pkg::op_beq: begin
                    rs_used = 1'b1;
                    rt_used = 1'b1;
                    is_beq  = 1'b1;
                end
                cpu_pkg::op_bne: begin
                    rs_used = 1'b1;
                    rt_used = 1'b1;
                    is_bne  = 1'b1;
                end
                default: alu_op = cpu_pkg::alu_nop;
            endcase
        end
    end

    always_comb begin
        val_a = pick(fwd_a, rdata_a);
        val_b = pick(fwd_b, rdata_b);
    end

    assign imm_ext     = imm_zero ? {16'h0, imm} : {{16{imm[15]}}, imm};
    assign branch_uses = is_beq || is_bne;
    assign id_advance  = id_valid && !id_stall;

    // resolved here, so only the delay slot follows the branch
    assign branch_taken  = id_advance && ((is_beq && (val_a == val_b)) ||
                                          (is_bne && (val_a != val_b)));
    assign branch_target = id_pc + cpu_pkg::inst_bytes + {{14{imm[15]}}, imm, 2'b00};

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
        end else begin
            ex_valid <= id_advance;         // bubble on stall or empty decode
            ex_wr    <= id_advance && wr;
        end
    end

    always_ff @(posedge aclk) begin
        if (id_advance) begin
            ex_pc     <= id_pc;
            ex_alu_op <= alu_op;
            ex_op_a   <= val_a;
            ex_op_b   <= use_imm ? imm_ext : val_b;
            ex_dst    <= dst;
        end
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               ex_valid,
    input  cpu_pkg::word_t     ex_pc,
    input  cpu_pkg::alu_op_t   ex_alu_op,
    input  cpu_pkg::word_t     ex_op_a,
    input  cpu_pkg::word_t     ex_op_b,
    input  cpu_pkg::reg_addr_t ex_dst,
    input  logic               ex_wr,
    output cpu_pkg::word_t     ex_result,
    output logic               wb_wr,
    output cpu_pkg::reg_addr_t wb_dst,
    output cpu_pkg::word_t     wb_result,
    output cpu_pkg::word_t     wb_pc
);

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::alu_add: ex_result = ex_op_a + ex_op_b;
            cpu_pkg::alu_sub: ex_result = ex_op_a - ex_op_b;
            cpu_pkg::alu_and: ex_result = ex_op_a & ex_op_b;
            cpu_pkg::alu_or:  ex_result = ex_op_a | ex_op_b;
            cpu_pkg::alu_xor: ex_result = ex_op_a ^ ex_op_b;
            cpu_pkg::alu_slt: ex_result = {31'h0, $signed(ex_op_a) < $signed(ex_op_b)};
            cpu_pkg::alu_lui: ex_result = {ex_op_b[15:0], 16'h0};
            default:          ex_result = '0;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wb_wr <= 1'b0;
        end else begin
            wb_wr <= ex_valid && ex_wr && (ex_dst != '0);   // r0 never retires a write
        end
    end

    // pc only moves for a real instruction, bubbles leave the trace alone
    always_ff @(posedge aclk) begin
        if (ex_valid) begin
            wb_pc     <= ex_pc;
            wb_dst    <= ex_dst;
            wb_result <= ex_result;
        end
    end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rt,
    input  logic               rs_used,
    input  logic               rt_used,
    input  logic               branch_uses,
    input  logic               ex_wr,
    input  cpu_pkg::reg_addr_t ex_dst,
    input  logic               wb_wr,
    input  cpu_pkg::reg_addr_t wb_dst,
    output cpu_pkg::fwd_sel_t  fwd_a,
    output cpu_pkg::fwd_sel_t  fwd_b,
    output logic               id_stall
);

    // execute has the younger value, so it wins over writeback
    function automatic cpu_pkg::fwd_sel_t select(cpu_pkg::reg_addr_t src, logic used);
        if (!used || src == '0) begin
            return cpu_pkg::fwd_rf;
        end else if (ex_wr && ex_dst == src) begin
            return cpu_pkg::fwd_ex;
        end else if (wb_wr && wb_dst == src) begin
            return cpu_pkg::fwd_wb;
        end
        return cpu_pkg::fwd_rf;
    endfunction

    always_comb begin
        fwd_a = select(rs, rs_used);
        fwd_b = select(rt, rt_used);
    end

    // a branch compare never takes the alu output of the same cycle
    assign id_stall = branch_uses && (fwd_a == cpu_pkg::fwd_ex || fwd_b == cpu_pkg::fwd_ex);

endmodule

//--- design/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic           aclk,
    input  logic           rst_n,
    output cpu_pkg::word_t araddr,
    output logic           arvalid,
    input  logic           arready,
    input  cpu_pkg::word_t rdata,
    input  logic           rvalid,
    output logic           rready,
    input  logic           id_advance,
    input  logic           id_stall,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    output logic           id_valid,
    output cpu_pkg::word_t id_pc,
    output cpu_pkg::word_t id_instr
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } fetch_state_t;

    fetch_state_t   state;
    cpu_pkg::word_t pc;             // address of the read in flight
    logic           pend_valid;     // target waits for the delay slot
    cpu_pkg::word_t pend_target;
    logic           r_fire;
    logic           take_now;

    assign araddr   = pc;
    assign arvalid  = (state == st_addr);
    // decode register empty, or its word leaves this cycle
    assign rready   = (state == st_data) && (!id_valid || !id_stall);
    assign r_fire   = rvalid && rready;
    assign take_now = id_advance && branch_taken;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: state <= st_addr;
                st_addr: begin
                    if (arready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (r_fire) begin
                        state <= st_addr;   // next request right after the word
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= reset_pc;
            pend_valid <= 1'b0;
        end else if (r_fire) begin
            pend_valid <= 1'b0;
            if (take_now) begin
                pc <= branch_target;    // branch leaves with its delay slot arriving
            end else if (pend_valid) begin
                pc <= pend_target;
            end else begin
                pc <= pc + cpu_pkg::inst_bytes;
            end
        end else if (take_now) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (take_now && !r_fire) begin
            pend_target <= branch_target;
        end
    end

    // decode register
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (r_fire) begin
            id_valid <= 1'b1;
        end else if (id_advance) begin
            id_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_fire) begin
            id_pc    <= pc;
            id_instr <= rdata;
        end
    end

endmodule

//--- design/mycpu_top.sv
`timescale 1ns/1ps

module mycpu_top #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic           aclk,
    input  logic           rst_n,
    output cpu_pkg::word_t araddr,
    output logic           arvalid,
    input  logic           arready,
    input  cpu_pkg::word_t rdata,
    input  logic           rvalid,
    output logic           rready,
    output cpu_pkg::word_t debug_wb_pc,
    output cpu_pkg::word_t debug_wb_rf_wdata,
    output logic [3:0]     debug_wb_rf_wen,
    output logic [4:0]     debug_wb_rf_wnum
);

    logic               id_valid;
    cpu_pkg::word_t     id_pc;
    cpu_pkg::word_t     id_instr;
    logic               id_advance;
    logic               id_stall;
    logic               branch_taken;
    cpu_pkg::word_t     branch_target;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    logic               rs_used;
    logic               rt_used;
    logic               branch_uses;
    cpu_pkg::fwd_sel_t  fwd_a;
    cpu_pkg::fwd_sel_t  fwd_b;
    cpu_pkg::reg_addr_t raddr_a;
    cpu_pkg::reg_addr_t raddr_b;
    cpu_pkg::word_t     rdata_a;
    cpu_pkg::word_t     rdata_b;

    // decode to execute
    logic               ex_valid;
    cpu_pkg::word_t     ex_pc;
    cpu_pkg::alu_op_t   ex_alu_op;
    cpu_pkg::word_t     ex_op_a;
    cpu_pkg::word_t     ex_op_b;
    cpu_pkg::reg_addr_t ex_dst;
    logic               ex_wr;
    cpu_pkg::word_t     ex_result;

    logic               wb_wr;
    cpu_pkg::reg_addr_t wb_dst;
    cpu_pkg::word_t     wb_result;
    cpu_pkg::word_t     wb_pc;

    // golden trace
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb_result;
    assign debug_wb_rf_wen   = wb_wr ? 4'hf : 4'h0;
    assign debug_wb_rf_wnum  = wb_dst;

    inst_fetch #(
        .reset_pc      (reset_pc)
    ) u_inst_fetch (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rvalid        (rvalid),
        .rready        (rready),
        .id_advance    (id_advance),
        .id_stall      (id_stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .id_instr      (id_instr)
    );

    decode_stage u_decode_stage (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .id_instr      (id_instr),
        .id_stall      (id_stall),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .ex_result     (ex_result),
        .wb_result     (wb_result),
        .rdata_a       (rdata_a),
        .rdata_b       (rdata_b),
        .id_advance    (id_advance),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .rs            (rs),
        .rt            (rt),
        .rs_used       (rs_used),
        .rt_used       (rt_used),
        .branch_uses   (branch_uses),
        .raddr_a       (raddr_a),
        .raddr_b       (raddr_b),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_alu_op     (ex_alu_op),
        .ex_op_a       (ex_op_a),
        .ex_op_b       (ex_op_b),
        .ex_dst        (ex_dst),
        .ex_wr         (ex_wr)
    );

    hazard_unit u_hazard_unit (
        .rs            (rs),
        .rt            (rt),
        .rs_used       (rs_used),
        .rt_used       (rt_used),
        .branch_uses   (branch_uses),
        .ex_wr         (ex_wr),
        .ex_dst        (ex_dst),
        .wb_wr         (wb_wr),
        .wb_dst        (wb_dst),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .id_stall      (id_stall)
    );

    execute_stage u_execute_stage (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_alu_op     (ex_alu_op),
        .ex_op_a       (ex_op_a),
        .ex_op_b       (ex_op_b),
        .ex_dst        (ex_dst),
        .ex_wr         (ex_wr),
        .ex_result     (ex_result),
        .wb_wr         (wb_wr),
        .wb_dst        (wb_dst),
        .wb_result     (wb_result),
        .wb_pc         (wb_pc)
    );

    reg_file u_reg_file (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .raddr_a       (raddr_a),
        .raddr_b       (raddr_b),
        .wb_wr         (wb_wr),
        .wb_dst        (wb_dst),
        .wb_result     (wb_result),
        .rdata_a       (rdata_a),
        .rdata_b       (rdata_b)
    );

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               aclk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t raddr_a,
    input  cpu_pkg::reg_addr_t raddr_b,
    input  logic               wb_wr,
    input  cpu_pkg::reg_addr_t wb_dst,
    input  cpu_pkg::word_t     wb_result,
    output cpu_pkg::word_t     rdata_a,
    output cpu_pkg::word_t     rdata_b
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wr && wb_dst != '0) begin
            regs[wb_dst] <= wb_result;
        end
    end

    // same-cycle writeback is covered by forwarding in decode
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- testbench/mycpu_checker.sv
`timescale 1ns/1ps

module mycpu_checker (
    input logic        aclk,
    input logic        rst_n,
    input logic [31:0] araddr,
    input logic        arvalid,
    input logic        arready,
    input logic        rvalid,
    input logic        rready,
    input logic [3:0]  debug_wb_rf_wen,
    input logic [4:0]  debug_wb_rf_wnum
);

    int   fail_count = 0;
    logic outstanding;      // address accepted, data not yet taken

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (arvalid && arready) begin
            outstanding <= 1'b1;
        end else if (rvalid && rready) begin
            outstanding <= 1'b0;
        end
    end

    ar_held: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            fail_count++;
            $error("arvalid dropped or araddr moved before arready");
        end

    ar_aligned: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid |-> araddr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("araddr is not word aligned");
        end

    one_in_flight: assert property (@(posedge aclk) disable iff (!rst_n)
        outstanding |-> !arvalid)
        else begin
            fail_count++;
            $error("second arvalid before the data of the first read");
        end

    rready_after_ar: assert property (@(posedge aclk) disable iff (!rst_n)
        rready |-> outstanding)
        else begin
            fail_count++;
            $error("rready raised with no read in flight");
        end

    wen_whole: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else begin
            fail_count++;
            $error("debug_wb_rf_wen is neither all zeros nor all ones");
        end

    no_r0_write: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wnum == 5'd0 |-> debug_wb_rf_wen == 4'h0)
        else begin
            fail_count++;
            $error("debug write reported for register 0");
        end

endmodule

bind mycpu_top mycpu_checker u_mycpu_checker (
    .aclk             (aclk),
    .rst_n            (rst_n),
    .araddr           (araddr),
    .arvalid          (arvalid),
    .arready          (arready),
    .rvalid           (rvalid),
    .rready           (rready),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

//--- testbench/tb_mycpu_top.sv
`timescale 1ns/1ps

module tb_mycpu_top;

    localparam int mem_words = 256;
    localparam int blocks    = 16;

    logic        aclk = 1'b0;
    logic        rst_n;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] mem [mem_words];
    int          wr_ptr;
    logic [4:0]  last_dst;          // steers the next source toward a dependence
    logic [31:0] loop_pc;
    int          model_count = 0;
    logic        loop_reached;

    // expected writes in program order
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_val [$];

    int writes_checked = 0;
    int value_errors = 0;
    int extra_writes = 0;
    int missing_writes = 0;
    int protocol_errors = 0;

    mycpu_top i_mycpu_top (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .araddr            (araddr),
        .arvalid           (arvalid),
        .arready           (arready),
        .rdata             (rdata),
        .rvalid            (rvalid),
        .rready            (rready),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #20 aclk = ~aclk;

    // unsupported opcode 0x3f, so stray fetches retire as no-ops
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ (addr >> 7) ^ (addr << 11);
        return {6'h3f, x[25:0]};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (addr < mem_words * 4) begin
            return mem[addr[9:2]];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_alu_word();
        logic [4:0]  dst;
        logic [4:0]  src_a;
        logic [4:0]  src_b;
        logic [15:0] imm;
        int          kind;
        dst   = ($urandom_range(9, 0) == 0) ? 5'd0 : 5'($urandom_range(7, 1));
        src_a = ($urandom_range(1, 0) == 1) ? last_dst : 5'($urandom_range(7, 0));
        src_b = 5'($urandom_range(7, 0));
        imm   = 16'($urandom());
        kind  = $urandom_range(8, 0);
        last_dst = dst;
        case (kind)
            0: return r_word(6'h21, dst, src_a, src_b);     // addu
            1: return r_word(6'h23, dst, src_a, src_b);     // subu
            2: return r_word(6'h24, dst, src_a, src_b);
            3: return r_word(6'h25, dst, src_a, src_b);
            4: return r_word(6'h26, dst, src_a, src_b);
            5: return r_word(6'h2a, dst, src_a, src_b);     // slt
            6: return i_word(6'h09, src_a, dst, imm);       // addiu
            7: return i_word(6'h0d, src_a, dst, imm);       // ori
            default: return i_word(6'h0f, 5'd0, dst, imm);  // lui
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[wr_ptr] = w;
        wr_ptr++;
    endtask

    task automatic build_program();
        int         kind;
        int         off;
        logic [4:0] a;
        logic [5:0] bop;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_word(32'(i * 4));
        end
        wr_ptr   = 0;
        last_dst = 5'd0;
        for (int blk = 0; blk < blocks; blk++) begin
            repeat (4) emit(random_alu_word());
            case ($urandom_range(2, 0))
                0: emit(32'h0000_0000);                     // all zeros
                1: emit(32'h8c22_0010);                     // lw, not in the kept set
                default: emit(r_word(6'h21, 5'd0, last_dst, last_dst));
            endcase
            kind = $urandom_range(3, 0);
            off  = $urandom_range(3, 1);
            bop  = ($urandom_range(1, 0) == 1) ? 6'h04 : 6'h05;
            case (kind)
                0: begin
                    // branch on the result just ahead of it
                    a = 5'($urandom_range(7, 1));
                    emit(i_word(6'h09, a, a, 16'($urandom_range(3, 0))));
                    emit(i_word(bop, a, 5'($urandom_range(7, 0)), 16'(off)));
                end
                1: emit(i_word(6'h04, 5'd0, 5'd0, 16'(off)));   // always taken
                2: emit(i_word(6'h05, 5'd0, 5'd0, 16'(off)));   // never taken
                default: emit(i_word(bop, last_dst, 5'($urandom_range(7, 0)), 16'(off)));
            endcase
            emit(random_alu_word());                    // delay slot
            repeat (off - 1) emit(random_alu_word());   // skipped when taken
        end
        loop_pc = 32'(wr_ptr * 4);
        emit(i_word(6'h04, 5'd0, 5'd0, 16'hffff));      // branch to itself
        emit(32'h0000_0000);
    endtask

    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] sext;
        logic [4:0]  dst;
        logic        wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc  = 32'h0;
        npc = 32'h4;
        while (pc != loop_pc && model_count < 10000) begin
            ins  = mem_word(pc);
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            sext = {{16{ins[15]}}, ins[15:0]};
            nnpc = npc + 32'd4;
            wr   = 1'b1;
            dst  = ins[20:16];
            res  = '0;
            case (ins[31:26])
                6'h00: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        6'h21: res = a + b;
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = a + sext;
                6'h0d: res = a | {16'h0, ins[15:0]};
                6'h0f: res = {ins[15:0], 16'h0};
                6'h04: begin
                    wr = 1'b0;
                    if (a == b) nnpc = pc + 32'd4 + (sext << 2);
                end
                6'h05: begin
                    wr = 1'b0;
                    if (a != b) nnpc = pc + 32'd4 + (sext << 2);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_pc.push_back(pc);
                exp_reg.push_back(dst);
                exp_val.push_back(res);
            end
            pc  = npc;
            npc = nnpc;
            model_count++;
        end
    endtask

    // AXI4-Lite read slave with random ready and valid delays
    task automatic serve_reads();
        logic        ar_fire;
        logic        r_fire;
        logic        ar_seen;
        logic [31:0] ar_addr;
        logic [31:0] rd_addr;
        logic        rd_pending;
        int          ar_wait;
        int          r_wait;
        ar_wait    = -1;
        r_wait     = 0;
        rd_pending = 1'b0;
        rd_addr    = '0;
        forever begin
            @(negedge aclk);
            ar_fire = arvalid && arready;
            r_fire  = rvalid && rready;
            ar_seen = arvalid;
            ar_addr = araddr;
            @(posedge aclk);
            #2;
            if (r_fire) begin
                rvalid = 1'b0;
            end
            if (rd_pending) begin
                if (r_wait == 0) begin
                    rvalid     = 1'b1;
                    rdata      = mem_word(rd_addr);
                    rd_pending = 1'b0;
                end else begin
                    r_wait--;
                end
            end
            if (ar_fire) begin
                arready    = 1'b0;
                ar_wait    = -1;
                rd_addr    = ar_addr;
                rd_pending = 1'b1;
                r_wait     = $urandom_range(3, 0);
            end else if (ar_seen) begin
                if (ar_wait < 0) ar_wait = $urandom_range(3, 0);
                if (ar_wait == 0) arready = 1'b1;
                else ar_wait--;
            end
        end
    endtask

    task automatic check_write();
        logic [31:0] e_pc;
        logic [4:0]  e_reg;
        logic [31:0] e_val;
        assert (exp_pc.size() > 0) else begin
            extra_writes++;
            $display("unexpected register write at %0t: pc %h r%0d = %h", $time,
                     debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
        end
        if (exp_pc.size() > 0) begin
            e_pc  = exp_pc.pop_front();
            e_reg = exp_reg.pop_front();
            e_val = exp_val.pop_front();
            writes_checked++;
            assert (debug_wb_pc === e_pc && debug_wb_rf_wnum === e_reg &&
                    debug_wb_rf_wdata === e_val) else begin
                value_errors++;
                $display("FAILED at %0t: expected pc %h r%0d = %h, got pc %h r%0d = %h",
                         $time, e_pc, e_reg, e_val,
                         debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
            end
        end
    endtask

    task automatic watch_writes();
        forever begin
            @(negedge aclk);
            if (rst_n && debug_wb_rf_wen != 4'h0) check_write();
            if (rst_n && debug_wb_pc === loop_pc) loop_reached = 1'b1;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        arready      = 1'b0;
        rvalid       = 1'b0;
        rdata        = '0;
        loop_reached = 1'b0;
        void'($urandom(32'hf76a_94ae));
        build_program();
        run_model();
        fork
            serve_reads();
            watch_writes();
        join_none
        repeat (4) @(posedge aclk);
        #2;
        rst_n = 1'b1;
        wait (loop_reached);
        repeat (2) @(posedge aclk);
        missing_writes = exp_pc.size();
        assert (missing_writes == 0) else begin
            $display("%0d expected register writes never retired", missing_writes);
        end
        protocol_errors = i_mycpu_top.u_mycpu_checker.fail_count;
        $display("writes checked %0d, value errors %0d, missing %0d, unexpected %0d, protocol %0d",
                 writes_checked, value_errors, missing_writes, extra_writes, protocol_errors);
        if (value_errors + missing_writes + extra_writes + protocol_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // 12 cycles per executed instruction, plus reset and startup
    initial begin
        @(posedge rst_n);
        #((model_count * 12 + 20) * 40);
        $display("timeout: the program did not reach its final loop");
        $display("Some tests failed");
        $finish;
    end

endmodule
